// ==== dv/frame_golden.txt ====
# name        op    arg       data      expect    (all numbers hex)
# rd: data is the expected rresp; joy, ps, pb: arg and data are {start, coin} in and out
status_wr     wr    00        a5a500fd  0
status_rd     rd    00        0         a5a500fc
dip_wr        wr    04        12345681  0
dip_rd        rd    04        0         81
id_rd         rd    08        0         4a544652
hole_rd       rd    0c        2         0
id_wr         wr    08        deadbeef  2
id_keep       rd    08        0         4a544652
stall_dip     bp    04        5a        5a
stall_status  bp    00        c3c30f0c  c3c30f0c
dl_short      dl    3         0         10
dl_long       dl    40        0         10
rst_req       rw    00        1         10
flip_on       rw    04        5b        10
flip_same     rw    04        5b        0
flip_off      rw    04        5a        10
joy_coin      joy   1         e         0
joy_start     joy   c         3         0
joy_mix       joy   6         9         0
pause_reg     ps    1         e         1
pause_clr_rd  rd    00        0         0
unpause_pin   pb    2         d         0
pause_pin     pb    0         f         1
unpause_reg   ps    3         c         0
snd_mid       snd   8000      0         0
snd_low       snd   0         0         800
snd_quarter   snd   4000      0         c00

// ==== sim.f ====
rtl/frame_cfg_pkg.sv
rtl/frame_io_pkg.sv
rtl/frame_ctrl_if.sv
rtl/frame_status_regs.sv
rtl/frame_reset.sv
rtl/frame_joystick.sv
rtl/frame_snd_dac.sv
rtl/frame_top.sv
dv/frame_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= frame_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

SRCS := $(shell cat sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/frame_tb.sv ====
`timescale 1ns/1ps

module frame_tb;

    localparam int timeout = 200;  // Cycles allowed per wait
    localparam logic [9:0] btn3_mask = 10'(1) << frame_io_pkg::joy_btn3_bit;

    logic        clk_rgb = 1'b0;
    logic        rst_n;
    logic [7:0]  s_axi_awaddr;
    logic [7:0]  s_axi_araddr;
    logic [31:0] s_axi_wdata;
    logic [31:0] s_axi_rdata;
    logic [3:0]  s_axi_wstrb;
    logic [1:0]  s_axi_bresp;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic        s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic        s_axi_rvalid, s_axi_rready;
    logic [9:0]  board_joystick1, board_joystick2, game_joystick1, game_joystick2;
    logic [1:0]  board_coin, board_start, game_coin, game_start;
    logic        board_pause, downloading, game_pause, game_rst, snd_pwm;
    logic [15:0] snd;

    logic [31:0] seed = 32'hf75a_63b7;
    string       test_name;
    string       op;
    logic        test_ok;
    int          n_tests = 0;
    int          n_failed = 0;

    frame_top #(.signed_snd(1'b1), .three_buttons(1'b0)) u_frame_top (.*);

    always #4 clk_rgb = ~clk_rgb;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act);
        assert (act === exp_v) else begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp_v, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic fault(input string why);
        $display("%s: %s", test_name, why);
        test_ok = 1'b0;
    endtask

    // With stall > 0 a second write sits on the bus while bready is low
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input int stall, output logic [1:0] resp);
        int n;
        @(negedge clk_rgb);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        n = 0;
        #2;
        while (!(s_axi_awready && s_axi_wready) && n < timeout) begin
            @(negedge clk_rgb);
            #2;
            n++;
        end
        if (!(s_axi_awready && s_axi_wready)) fault("write was never accepted");
        @(negedge clk_rgb);  // Accept edge is behind us
        s_axi_wdata   = ~data;
        s_axi_awvalid = stall > 0;
        s_axi_wvalid  = stall > 0;
        s_axi_bready  = stall == 0;
        #2;
        check("bvalid", 1, s_axi_bvalid);
        resp = s_axi_bresp;
        for (int i = 0; i < stall; i++) begin
            @(negedge clk_rgb);
            #2;
            check("awready under stall", 0, s_axi_awready);
            check("wready under stall", 0, s_axi_wready);
            check("bvalid under stall", 1, s_axi_bvalid);
            check("bresp under stall", resp, s_axi_bresp);
        end
        if (stall > 0) begin
            @(negedge clk_rgb);
            s_axi_awvalid = 1'b0;
            s_axi_wvalid  = 1'b0;
            s_axi_bready  = 1'b1;
        end
        @(negedge clk_rgb);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        @(negedge clk_rgb);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        n = 0;
        #2;
        while (!s_axi_arready && n < timeout) begin
            @(negedge clk_rgb);
            #2;
            n++;
        end
        if (!s_axi_arready) fault("read address was never accepted");
        @(negedge clk_rgb);
        s_axi_araddr  = frame_cfg_pkg::reg_id_addr;  // Second read that must wait
        s_axi_arvalid = stall > 0;
        s_axi_rready  = stall == 0;
        #2;
        check("rvalid", 1, s_axi_rvalid);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        for (int i = 0; i < stall; i++) begin
            @(negedge clk_rgb);
            #2;
            check("arready under stall", 0, s_axi_arready);
            check("rvalid under stall", 1, s_axi_rvalid);
            check("rdata under stall", data, s_axi_rdata);
            check("rresp under stall", resp, s_axi_rresp);
        end
        if (stall > 0) begin
            @(negedge clk_rgb);
            s_axi_arvalid = 1'b0;
            s_axi_rready  = 1'b1;
        end
        @(negedge clk_rgb);
        s_axi_rready = 1'b0;
    endtask

    // Cycles from here until game_rst falls
    task automatic hold_cycles(output int n);
        n = 0;
        while (game_rst && n < timeout) begin
            @(negedge clk_rgb);
            n++;
        end
        if (game_rst) fault("game_rst never fell");
    endtask

    // Random sticks with fixed coin and start, outputs one cycle later
    task automatic check_controls(input logic [3:0] cs, input logic [3:0] exp_cs,
                                  input logic paused);
        logic [9:0] exp1;
        logic [9:0] exp2;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk_rgb);
            seed = lcg_next(seed);
            board_joystick1 = seed[9:0];
            board_joystick2 = seed[25:16];
            board_coin      = cs[1:0];
            board_start     = cs[3:2];
            exp1 = paused ? '1 : (~seed[9:0] | btn3_mask);
            exp2 = paused ? '1 : (~seed[25:16] | btn3_mask);
            @(negedge clk_rgb);
            check("game_pause", paused, game_pause);
            check("game_joystick1", exp1, game_joystick1);
            check("game_joystick2", exp2, game_joystick2);
            check("start and coin", exp_cs, {game_start, game_coin});
        end
    endtask

    task automatic run_test(input logic [31:0] arg, input logic [31:0] data,
                            input logic [31:0] exp_v);
        logic [1:0]  resp;
        logic [31:0] rdata;
        int          n;
        int          stall;
        test_ok = 1'b1;
        if (op == "wr") begin
            axi_write(arg[7:0], data, 0, resp);
            check("bresp", exp_v, resp);
        end else if (op == "rd") begin
            axi_read(arg[7:0], 0, rdata, resp);
            check("rresp", data, resp);
            check("rdata", exp_v, rdata);
        end else if (op == "bp") begin
            seed = lcg_next(seed);
            stall = 2 + int'(seed[18:16]);
            axi_write(arg[7:0], data, stall, resp);
            check("bresp", 32'(frame_cfg_pkg::axi_resp_okay), resp);
            seed = lcg_next(seed);
            stall = 2 + int'(seed[18:16]);
            axi_read(arg[7:0], stall, rdata, resp);
            check("rdata", exp_v, rdata);
        end else if (op == "dl") begin
            @(negedge clk_rgb);
            downloading = 1'b1;
            for (int i = 0; i < arg; i++) begin
                @(negedge clk_rgb);
                check("game_rst while downloading", 1, game_rst);
            end
            downloading = 1'b0;
            hold_cycles(n);
            check("hold cycles", exp_v, n);
        end else if (op == "rw") begin
            hold_cycles(n);  // Let an earlier reset run out
            axi_write(arg[7:0], data, 0, resp);
            hold_cycles(n);
            check("hold cycles", exp_v, n);
        end else if (op == "joy") begin
            check_controls(arg[3:0], data[3:0], 1'b0);
        end else if (op == "ps" || op == "pb") begin
            if (op == "ps") begin
                axi_write(frame_cfg_pkg::reg_status_addr,
                          32'(1) << frame_io_pkg::status_pause_bit, 0, resp);
            end else begin
                @(negedge clk_rgb);
                board_pause = 1'b1;
                @(negedge clk_rgb);
                board_pause = 1'b0;
            end
            check_controls(arg[3:0], data[3:0], exp_v[0]);
        end else if (op == "snd") begin
            @(negedge clk_rgb);
            rst_n = 1'b0;
            snd   = arg[15:0];
            repeat (2) @(negedge clk_rgb);
            rst_n = 1'b1;
            n = 0;
            for (int i = 0; i < 4096; i++) begin
                @(negedge clk_rgb);
                if (snd_pwm) n++;
            end
            check("ones in 4096 cycles", exp_v, n);
        end else begin
            fault("unknown operation in golden file");
        end
        n_tests++;
        if (!test_ok) n_failed++;
        $display("%-14s %s", test_name, test_ok ? "ok" : "failed");
    endtask

    initial begin
        int          fd;
        string       line;
        logic [31:0] arg, data, exp_v;
        rst_n           = 1'b0;
        s_axi_awaddr    = '0;
        s_axi_awvalid   = 1'b0;
        s_axi_wdata     = '0;
        s_axi_wstrb     = 4'hf;
        s_axi_wvalid    = 1'b0;
        s_axi_bready    = 1'b0;
        s_axi_araddr    = '0;
        s_axi_arvalid   = 1'b0;
        s_axi_rready    = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_coin      = '0;
        board_start     = '0;
        board_pause     = 1'b0;
        downloading     = 1'b0;
        snd             = '0;
        repeat (2) @(negedge clk_rgb);
        rst_n = 1'b1;
        fd = $fopen("dv/frame_golden.txt", "r");
        if (fd == 0) $display("Cannot open dv/frame_golden.txt");
        while (fd != 0 && $fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%s %s %h %h %h", test_name, op, arg, data, exp_v) == 5) begin
                run_test(arg, data, exp_v);
            end
        end
        if (fd != 0) $fclose(fd);
        $display("%0d tests run, %0d failed", n_tests, n_failed);
        if (n_failed == 0 && n_tests > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== rtl/frame_top.sv ====
`timescale 1ns/1ps

module frame_top #(
    parameter bit signed_snd    = 1'b0,
    parameter bit three_buttons = 1'b0
) (
    input  logic                                clk_rgb,
    input  logic                                rst_n,
    // AXI4-Lite from the I/O microcontroller
    input  logic [frame_cfg_pkg::axi_addr_w-1:0] s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [frame_cfg_pkg::axi_data_w-1:0] s_axi_wdata,
    input  logic [frame_cfg_pkg::axi_strb_w-1:0] s_axi_wstrb,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,
    output logic [1:0]                          s_axi_bresp,
    output logic                                s_axi_bvalid,
    input  logic                                s_axi_bready,
    input  logic [frame_cfg_pkg::axi_addr_w-1:0] s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output logic [frame_cfg_pkg::axi_data_w-1:0] s_axi_rdata,
    output logic [1:0]                          s_axi_rresp,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready,
    // Board controls, active high
    input  logic [frame_io_pkg::joy_w-1:0]       board_joystick1,
    input  logic [frame_io_pkg::joy_w-1:0]       board_joystick2,
    input  logic [frame_io_pkg::players-1:0]     board_coin,
    input  logic [frame_io_pkg::players-1:0]     board_start,
    input  logic                                board_pause,
    input  logic                                downloading,
    input  logic [frame_cfg_pkg::snd_w-1:0]      snd,
    // Game side, active low controls
    output logic [frame_io_pkg::joy_w-1:0]       game_joystick1,
    output logic [frame_io_pkg::joy_w-1:0]       game_joystick2,
    output logic [frame_io_pkg::players-1:0]     game_coin,
    output logic [frame_io_pkg::players-1:0]     game_start,
    output logic                                game_pause,
    output logic                                game_rst,
    output logic                                snd_pwm
);

    frame_ctrl_if ctrl ();

    frame_status_regs u_regs (
        .clk_rgb       ( clk_rgb       ),
        .rst_n         ( rst_n         ),
        .s_axi_awaddr  ( s_axi_awaddr  ),
        .s_axi_awvalid ( s_axi_awvalid ),
        .s_axi_awready ( s_axi_awready ),
        .s_axi_wdata   ( s_axi_wdata   ),
        .s_axi_wstrb   ( s_axi_wstrb   ),
        .s_axi_wvalid  ( s_axi_wvalid  ),
        .s_axi_wready  ( s_axi_wready  ),
        .s_axi_bresp   ( s_axi_bresp   ),
        .s_axi_bvalid  ( s_axi_bvalid  ),
        .s_axi_bready  ( s_axi_bready  ),
        .s_axi_araddr  ( s_axi_araddr  ),
        .s_axi_arvalid ( s_axi_arvalid ),
        .s_axi_arready ( s_axi_arready ),
        .s_axi_rdata   ( s_axi_rdata   ),
        .s_axi_rresp   ( s_axi_rresp   ),
        .s_axi_rvalid  ( s_axi_rvalid  ),
        .s_axi_rready  ( s_axi_rready  ),
        .ctrl          ( ctrl.regs     )
    );

    frame_reset u_reset (
        .clk_rgb     ( clk_rgb     ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ctrl        ( ctrl.board  ),
        .game_rst    ( game_rst    )
    );

    frame_joystick #(.three_buttons(three_buttons)) u_joystick (
        .clk_rgb         ( clk_rgb         ),
        .rst_n           ( rst_n           ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .board_coin      ( board_coin      ),
        .board_start     ( board_start     ),
        .board_pause     ( board_pause     ),
        .ctrl            ( ctrl.board      ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_pause      ( game_pause      )
    );

    frame_snd_dac #(.signed_snd(signed_snd)) u_dac (
        .clk_rgb ( clk_rgb ),
        .rst_n   ( rst_n   ),
        .snd     ( snd     ),
        .snd_pwm ( snd_pwm )
    );

endmodule

// ==== rtl/frame_snd_dac.sv ====
`timescale 1ns/1ps

module frame_snd_dac #(
    parameter bit signed_snd = 1'b0
) (
    input  logic                           clk_rgb,
    input  logic                           rst_n,
    input  logic [frame_cfg_pkg::snd_w-1:0] snd,
    output logic                           snd_pwm
);

    localparam int snd_w = frame_cfg_pkg::snd_w;

    logic [snd_w-1:0] level;
    logic [snd_w-1:0] acc;
    logic [snd_w:0]   sum;   // Carry on top

    // Offset binary for signed input
    assign level = signed_snd ? {~snd[snd_w-1], snd[snd_w-2:0]} : snd;
    assign sum   = {1'b0, acc} + {1'b0, level};

    always_ff @(posedge clk_rgb) begin
        if (!rst_n) begin
            acc     <= '0;
            snd_pwm <= 1'b0;
        end else begin
            acc     <= sum[snd_w-1:0];
            snd_pwm <= sum[snd_w];  // Density tracks level / 2^snd_w
        end
    end

endmodule

// ==== rtl/frame_joystick.sv ====
`timescale 1ns/1ps

module frame_joystick #(
    parameter bit three_buttons = 1'b0
) (
    input  logic                            clk_rgb,
    input  logic                            rst_n,
    input  logic [frame_io_pkg::joy_w-1:0]   board_joystick1,
    input  logic [frame_io_pkg::joy_w-1:0]   board_joystick2,
    input  logic [frame_io_pkg::players-1:0] board_coin,
    input  logic [frame_io_pkg::players-1:0] board_start,
    input  logic                            board_pause,
    frame_ctrl_if.board                     ctrl,
    output logic [frame_io_pkg::joy_w-1:0]   game_joystick1,
    output logic [frame_io_pkg::joy_w-1:0]   game_joystick2,
    output logic [frame_io_pkg::players-1:0] game_coin,
    output logic [frame_io_pkg::players-1:0] game_start,
    output logic                            game_pause
);

    localparam int joy_w = frame_io_pkg::joy_w;

    // Unused third button kept released
    localparam logic [joy_w-1:0] btn_mask =
        three_buttons ? '0 : (joy_w'(1) << frame_io_pkg::joy_btn3_bit);

    logic board_pause_q;
    logic pause_toggle;

    assign pause_toggle = ctrl.pause_req || (board_pause && !board_pause_q);

    always_ff @(posedge clk_rgb) begin
        if (!rst_n) begin
            board_pause_q  <= 1'b0;
            game_pause     <= 1'b0;
            game_joystick1 <= '1;  // Game side is active low
            game_joystick2 <= '1;
            game_coin      <= '1;
            game_start     <= '1;
        end else begin
            board_pause_q <= board_pause;
            if (pause_toggle) game_pause <= !game_pause;
            // Sticks frozen while paused
            game_joystick1 <= game_pause ? '1 : (~board_joystick1 | btn_mask);
            game_joystick2 <= game_pause ? '1 : (~board_joystick2 | btn_mask);
            game_coin      <= ~board_coin;
            game_start     <= ~board_start;
        end
    end

endmodule

// ==== rtl/frame_reset.sv ====
`timescale 1ns/1ps

module frame_reset (
    input  logic       clk_rgb,
    input  logic       rst_n,
    input  logic       downloading,
    frame_ctrl_if.board ctrl,
    output logic       game_rst
);

    localparam int cnt_w = $clog2(frame_cfg_pkg::reset_hold + 1);
    localparam logic [cnt_w-1:0] hold = cnt_w'(frame_cfg_pkg::reset_hold);

    logic             flip_q;   // Flip DIP one cycle back
    logic             flip_chg;
    logic             cause;
    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] cnt_next;

    assign flip_chg = ctrl.dip[frame_io_pkg::dip_flip_bit] != flip_q;
    assign cause    = downloading || ctrl.rst_req || flip_chg;

    // Any cause reloads, otherwise drain to zero
    always_comb begin
        if (cause) begin
            cnt_next = hold;
        end else if (cnt != '0) begin
            cnt_next = cnt - 1'b1;
        end else begin
            cnt_next = '0;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (!rst_n) begin
            flip_q   <= 1'b0;
            cnt      <= hold;
            game_rst <= 1'b1;
        end else begin
            flip_q   <= ctrl.dip[frame_io_pkg::dip_flip_bit];
            cnt      <= cnt_next;
            game_rst <= cnt_next != '0; // Low hold cycles after the last cause
        end
    end

endmodule

// ==== rtl/frame_status_regs.sv ====
`timescale 1ns/1ps

module frame_status_regs (
    input  logic                                clk_rgb,
    input  logic                                rst_n,
    input  logic [frame_cfg_pkg::axi_addr_w-1:0] s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [frame_cfg_pkg::axi_data_w-1:0] s_axi_wdata,
    input  logic [frame_cfg_pkg::axi_strb_w-1:0] s_axi_wstrb,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,
    output logic [1:0]                          s_axi_bresp,
    output logic                                s_axi_bvalid,
    input  logic                                s_axi_bready,
    input  logic [frame_cfg_pkg::axi_addr_w-1:0] s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output logic [frame_cfg_pkg::axi_data_w-1:0] s_axi_rdata,
    output logic [1:0]                          s_axi_rresp,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready,
    frame_ctrl_if.regs                          ctrl
);

    localparam int data_w = frame_cfg_pkg::axi_data_w;
    localparam int dip_w  = frame_io_pkg::dip_w;
    localparam int rst_b  = frame_io_pkg::status_rst_req_bit;
    localparam int pause_b = frame_io_pkg::status_pause_bit;

    // Bits that never hold a value
    localparam logic [data_w-1:0] self_clr = (data_w'(1) << rst_b) | (data_w'(1) << pause_b);

    logic              wr_accept;
    logic              rd_accept;
    logic              wr_status;
    logic              wr_dip;
    logic [data_w-1:0] wmask;
    logic [data_w-1:0] status_new;
    logic [data_w-1:0] rd_data;
    logic [1:0]        rd_resp;

    // One cycle handshake, stalled while a response waits
    assign wr_accept     = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
    assign s_axi_awready = wr_accept;
    assign s_axi_wready  = wr_accept;
    assign rd_accept     = s_axi_arvalid && !s_axi_rvalid;
    assign s_axi_arready = rd_accept;

    assign wr_status = s_axi_awaddr == frame_cfg_pkg::reg_status_addr;
    assign wr_dip    = s_axi_awaddr == frame_cfg_pkg::reg_dip_addr;

    always_comb begin
        for (int i = 0; i < frame_cfg_pkg::axi_strb_w; i++) begin
            wmask[8*i +: 8] = {8{s_axi_wstrb[i]}};
        end
    end

    assign status_new = ((ctrl.status & ~wmask) | (s_axi_wdata & wmask)) & ~self_clr;

    always_ff @(posedge clk_rgb) begin
        if (!rst_n) begin
            ctrl.status    <= '0;
            ctrl.dip       <= '0;
            ctrl.rst_req   <= 1'b0;
            ctrl.pause_req <= 1'b0;
            s_axi_bvalid   <= 1'b0;
        end else begin
            // Pulses fire only with the byte lane enabled
            ctrl.rst_req   <= wr_accept && wr_status && wmask[rst_b] && s_axi_wdata[rst_b];
            ctrl.pause_req <= wr_accept && wr_status && wmask[pause_b] && s_axi_wdata[pause_b];
            if (wr_accept) begin
                s_axi_bvalid <= 1'b1;
                if (wr_status) ctrl.status <= status_new;
                if (wr_dip) begin
                    ctrl.dip <= (ctrl.dip & ~wmask[dip_w-1:0])
                              | (s_axi_wdata[dip_w-1:0] & wmask[dip_w-1:0]);
                end
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (wr_accept) begin
            // ID and holes refuse the write
            s_axi_bresp <= (wr_status || wr_dip) ? frame_cfg_pkg::axi_resp_okay
                                                 : frame_cfg_pkg::axi_resp_slverr;
        end
    end

    always_comb begin
        rd_data = '0;
        rd_resp = frame_cfg_pkg::axi_resp_okay;
        case (s_axi_araddr)
            frame_cfg_pkg::reg_status_addr: rd_data = ctrl.status;
            frame_cfg_pkg::reg_dip_addr:    rd_data = {{(data_w-dip_w){1'b0}}, ctrl.dip};
            frame_cfg_pkg::reg_id_addr:     rd_data = frame_cfg_pkg::frame_id;
            default:                        rd_resp = frame_cfg_pkg::axi_resp_slverr;
        endcase
    end

    always_ff @(posedge clk_rgb) begin
        if (!rst_n) begin
            s_axi_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (rd_accept) begin
            s_axi_rdata <= rd_data;
            s_axi_rresp <= rd_resp;
        end
    end

endmodule

// ==== rtl/frame_ctrl_if.sv ====
`timescale 1ns/1ps

interface frame_ctrl_if;

    logic [frame_io_pkg::status_w-1:0] status;   // Stored status word
    logic [frame_io_pkg::dip_w-1:0]    dip;
    logic                              rst_req;  // One cycle pulse
    logic                              pause_req; // One cycle pulse

    modport regs (
        output status,
        output dip,
        output rst_req,
        output pause_req
    );

    modport board (
        input status,
        input dip,
        input rst_req,
        input pause_req
    );

endinterface

// ==== rtl/frame_io_pkg.sv ====
package frame_io_pkg;

    // Board side word widths
    localparam int joy_w    = 10;
    localparam int players  = 2;  // Coin and start lines
    localparam int status_w = 32;
    localparam int dip_w    = 8;

    // Third fire button in the joystick word
    localparam int joy_btn3_bit = 6;

    // Status word, both bits clear themselves after the write
    localparam int status_rst_req_bit = 0;
    localparam int status_pause_bit   = 1;

    // DIP register
    localparam int dip_flip_bit = 0; // Screen flip, a change forces a game reset

endpackage

// ==== rtl/frame_cfg_pkg.sv ====
package frame_cfg_pkg;

    // AXI4-Lite bus shape
    localparam int axi_addr_w = 8;
    localparam int axi_data_w = 32;
    localparam int axi_strb_w = axi_data_w / 8;

    // Register map, byte addresses
    localparam logic [axi_addr_w-1:0] reg_status_addr = 8'h00;
    localparam logic [axi_addr_w-1:0] reg_dip_addr    = 8'h04;
    localparam logic [axi_addr_w-1:0] reg_id_addr     = 8'h08; // Read only

    localparam logic [axi_data_w-1:0] frame_id = 32'h4A54_4652;

    localparam logic [1:0] axi_resp_okay   = 2'd0;
    localparam logic [1:0] axi_resp_slverr = 2'd2;

    // Cycles game_rst stays up once every cause has gone
    localparam int reset_hold = 16;

    localparam int snd_w = 16;

endpackage
